// File: tb/csr_cases.txt
// op acc addr wdata cmd sel cause events hold exp_rdata exp_busy exp_irq
// op 0 none 1 write 2 set 3 clear, cmd 0 none 1 trap 2 mret, sel 0 id 1 if 2 branch 3 load
// reset values
0 1 300 00000000 0 0 00 0000 1 00001800 0 0
0 1 341 00000000 0 0 00 0000 1 00000000 0 0
0 1 342 00000000 0 0 00 0000 1 00000000 0 0
0 1 305 00000000 0 0 00 0000 1 1c008000 0 0
0 1 f14 00000000 0 0 00 0000 1 00000545 0 0
0 1 014 00000000 0 0 00 0000 1 00000545 0 0
0 1 301 00000000 0 0 00 0000 1 00000000 0 0
0 1 f11 00000000 0 0 00 0000 1 00000000 0 0
0 1 f12 00000000 0 0 00 0000 1 00000000 0 0
0 1 f13 00000000 0 0 00 0000 1 00000000 0 0
0 1 123 00000000 0 0 00 0000 1 00000000 0 0
0 1 7a1 00000000 0 0 00 0000 1 00000003 0 0
0 1 7a0 00000000 0 0 00 0000 1 00000000 0 0
// register operations
1 1 300 ffffffff 0 0 00 0000 1 00001800 0 0
0 1 300 00000000 0 0 00 0000 1 00001888 0 1
3 1 300 00000008 0 0 00 0000 1 00001888 0 1
0 1 300 00000000 0 0 00 0000 1 00001880 0 0
2 1 300 00000008 0 0 00 0000 1 00001880 0 0
0 1 300 00000000 0 0 00 0000 1 00001888 0 1
1 1 341 12345678 0 0 00 0000 1 00000000 1 1
2 1 341 0000f000 0 0 00 0000 1 12345678 1 1
3 1 341 00000678 0 0 00 0000 1 1234f678 1 1
0 1 341 00000000 0 0 00 0000 1 1234f000 0 1
1 1 305 dead0000 0 0 00 0000 1 1c008000 1 1
0 1 305 00000000 0 0 00 0000 1 1c008000 0 1
1 1 342 8000001f 0 0 00 0000 1 00000000 0 1
0 1 342 00000000 0 0 00 0000 1 8000001f 0 1
3 1 342 80000010 0 0 00 0000 1 8000001f 0 1
0 1 342 00000000 0 0 00 0000 1 0000000f 0 1
// trap entry
0 1 300 00000000 1 0 02 0000 1 00001888 0 1
0 1 341 00000000 0 0 00 0000 1 00002008 0 0
0 1 342 00000000 0 0 00 0000 1 00000002 0 0
0 1 300 00000000 0 0 00 0000 1 00001880 0 0
1 1 341 aaaa0000 1 1 2b 0000 1 00002008 1 0
0 1 341 00000000 0 0 00 0000 1 00001004 0 0
0 1 342 00000000 0 0 00 0000 1 8000000b 0 0
0 1 300 00000000 0 0 00 0000 1 00001800 0 0
2 1 300 00000008 0 0 00 0000 1 00001800 0 0
0 1 300 00000000 1 3 05 0000 1 00001808 0 1
0 1 341 00000000 0 0 00 0000 1 0000300c 0 0
0 1 300 00000000 0 0 00 0000 1 00001880 0 0
0 1 342 00000000 1 2 07 0000 1 00000005 0 0
0 1 341 00000000 0 0 00 0000 1 00004010 0 0
0 1 342 00000000 0 0 00 0000 1 00000007 0 0
// mret
2 1 300 00000080 0 0 00 0000 1 00001800 0 0
0 1 341 00000000 2 0 00 0000 1 00004010 0 0
0 1 300 00000000 0 0 00 0000 1 00001888 0 1
0 1 300 00000000 1 0 03 0000 1 00001888 0 1
0 1 300 00000000 2 0 00 0000 1 00001880 0 0
0 1 300 00000000 0 0 00 0000 1 00001888 0 1
// counters, pcer enables cycle and load
1 1 7a0 00000021 0 0 00 0000 1 00000000 0 1
0 1 785 00000000 0 0 00 1802 5 00000000 0 1
0 1 785 00000000 0 0 00 0000 1 00000004 0 1
0 1 785 00000000 0 0 00 0000 1 00000005 0 1
0 1 780 00000000 0 0 00 0000 1 00000006 0 1
0 1 781 00000000 0 0 00 0000 1 00000000 0 1
0 1 786 00000000 0 0 00 0000 1 00000000 0 1
3 1 7a1 00000001 0 0 00 0000 1 00000003 0 1
0 1 7a1 00000000 0 0 00 0000 1 00000002 0 1
0 1 780 00000000 0 0 00 0000 1 0000000b 0 1
0 1 785 00000000 0 0 00 0002 3 00000005 0 1
0 1 780 00000000 0 0 00 0000 1 0000000b 0 1
0 1 785 00000000 0 0 00 0000 1 00000005 0 1
0 1 7a0 00000000 0 0 00 0000 1 00000021 0 1
// counter writes and saturation
1 1 79f 00000100 0 0 00 0000 1 00000000 0 1
0 1 780 00000000 0 0 00 0000 1 00000100 0 1
0 1 78b 00000000 0 0 00 0000 1 00000100 0 1
0 1 785 00000000 0 0 00 0000 1 00000100 0 1
1 1 785 ffffffff 0 0 00 0000 1 00000100 0 1
1 1 7a1 00000003 0 0 00 0000 1 00000002 0 1
0 1 785 00000000 0 0 00 0002 3 ffffffff 0 1
0 1 785 00000000 0 0 00 0000 1 ffffffff 0 1
0 1 785 00000000 0 0 00 0000 1 ffffffff 0 1
3 1 7a1 00000002 0 0 00 0000 1 00000003 0 1
0 1 785 00000000 0 0 00 0002 1 ffffffff 0 1
0 1 785 00000000 0 0 00 0000 1 ffffffff 0 1
0 1 785 00000000 0 0 00 0000 1 00000000 0 1
// end marker
ff

// File: tb.f
source/csr_pkg.sv
source/perf_pkg.sv
source/csr_access_unit.sv
source/machine_trap_regs.sv
source/perf_event_sampler.sv
source/perf_counter_bank.sv
source/csr_file_top.sv
tb/csr_file_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile and run the CSR file testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  -f tb.f \
  --top-module csr_file_tb \
  -o csr_sim

./obj_dir/csr_sim | tee sim.log

if grep -qx '>>> PASS' sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

// File: tb/csr_file_tb.sv
// CSR file testbench with clock, reset, case reader, drivers, checks and report
`default_nettype none

module csr_file_tb
  import csr_pkg::*;
  import perf_pkg::*;
();

  localparam int N_FIELDS  = 12;
  localparam int MAX_CASES = 128;

  // fixed ids, boot address and candidate pcs
  localparam logic [3:0]  CORE_ID    = 4'h5;
  localparam logic [5:0]  CLUSTER_ID = 6'h2A;
  localparam logic [23:0] BOOT_ADDR  = 24'h1C_0080;

  logic         clk;
  logic         rst_n;
  csr_req_t     csr_req;
  trap_ctrl_t   trap;
  pc_set_t      pcs;
  perf_events_t events;
  csr_data_t    csr_rdata;
  logic         csr_busy;
  logic         irq_enable;
  csr_data_t    epc;

  // flat case table of N_FIELDS words per case
  logic [31:0] case_mem [MAX_CASES*N_FIELDS];
  int          n_cases;
  int          max_hold;
  int          cycle_cnt;
  int          cycle_limit;
  int          rdata_errs;
  int          busy_errs;
  int          irq_errs;
  int          epc_errs;
  int          load_errs;

  csr_file_top #(
    .COUNTER_W (32)
  ) DUT (
    .clk          (clk),
    .rst_n        (rst_n),
    .core_id_i    (CORE_ID),
    .cluster_id_i (CLUSTER_ID),
    .boot_addr_i  (BOOT_ADDR),
    .csr_req_i    (csr_req),
    .trap_i       (trap),
    .pcs_i        (pcs),
    .events_i     (events),
    .csr_rdata_o  (csr_rdata),
    .csr_busy_o   (csr_busy),
    .irq_enable_o (irq_enable),
    .epc_o        (epc)
  );

  always #5 clk = ~clk;

  //////////////////////////////
  // timeout
  //////////////////////////////
  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
      $display("timeout after %0d cycles, the case sequence did not complete", cycle_cnt);
      $display(">>> FAIL");
      $finish;
    end
  end

  // no request, no trap, no events
  task automatic drive_idle();
    csr_req = '0;
    trap    = '0;
    events  = '0;
  endtask

  // end marker ff in the op column
  task automatic count_cases();
    n_cases  = 0;
    max_hold = 1;
    while (n_cases < MAX_CASES && case_mem[n_cases*N_FIELDS] != 32'hFF) begin
      if (int'(case_mem[n_cases*N_FIELDS+8]) > max_hold) begin
        max_hold = int'(case_mem[n_cases*N_FIELDS+8]);
      end
      n_cases++;
    end
  endtask

  task automatic check_outputs(input int idx, input csr_addr_t addr,
                               input csr_data_t exp_rdata, input logic exp_busy,
                               input logic exp_irq);
    assert (csr_rdata === exp_rdata) else begin
      $display("FAILED at %0t: csr_rdata_o = %h, expected %h (case %0d, addr %h)",
               $time, csr_rdata, exp_rdata, idx, addr);
      rdata_errs++;
    end
    assert (csr_busy === exp_busy) else begin
      $display("FAILED at %0t: csr_busy_o = %b, expected %b (case %0d)",
               $time, csr_busy, exp_busy, idx);
      busy_errs++;
    end
    assert (irq_enable === exp_irq) else begin
      $display("FAILED at %0t: irq_enable_o = %b, expected %b (case %0d)",
               $time, irq_enable, exp_irq, idx);
      irq_errs++;
    end
    // return pc always mirrors mepc
    if (addr == CSR_MEPC) begin
      assert (epc === exp_rdata) else begin
        $display("FAILED at %0t: epc_o = %h, expected %h (case %0d)",
                 $time, epc, exp_rdata, idx);
        epc_errs++;
      end
    end
  endtask

  //////////////////////////////
  // one case
  //////////////////////////////
  task automatic run_case(input int idx);
    logic [31:0] fld [N_FIELDS];
    int          hold;
    for (int k = 0; k < N_FIELDS; k++) begin
      fld[k] = case_mem[idx*N_FIELDS+k];
    end
    hold = int'(fld[8]);
    @(negedge clk);
    csr_req.op     = csr_op_e'(fld[0][1:0]);
    csr_req.access = fld[1][0];
    csr_req.addr   = fld[2][11:0];
    csr_req.wdata  = fld[3];
    trap           = '0;
    if (fld[4] == 32'd1) begin
      trap.save_cause = 1'b1;
      trap.cause      = fld[6][5:0];
      case (fld[5][1:0])
        2'd0: trap.save_id = 1'b1;
        2'd1: trap.save_if = 1'b1;
        2'd2: trap.save_taken_branch = 1'b1;
        // load fault wins over a fetch save
        default: begin
          trap.save_if         = 1'b1;
          trap.data_load_event = 1'b1;
        end
      endcase
    end else if (fld[4] == 32'd2) begin
      trap.restore_mret = 1'b1;
    end
    events = fld[7][12:0];
    // mid low phase with outputs settled
    #1;
    check_outputs(idx, fld[2][11:0], fld[9], fld[10][0], fld[11][0]);
    // events stay while request and trap last one cycle
    for (int h = 1; h < hold; h++) begin
      @(negedge clk);
      csr_req = '0;
      trap    = '0;
    end
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////
  initial begin
    clk         = 1'b0;
    rst_n       = 1'b0;
    cycle_cnt   = 0;
    cycle_limit = 0;
    rdata_errs  = 0;
    busy_errs   = 0;
    irq_errs    = 0;
    epc_errs    = 0;
    load_errs   = 0;
    pcs.pc_if         = 32'h0000_1004;
    pcs.pc_id         = 32'h0000_2008;
    pcs.pc_ex         = 32'h0000_300C;
    pcs.branch_target = 32'h0000_4010;
    drive_idle();

    $readmemh("tb/csr_cases.txt", case_mem);
    count_cases();
    if (n_cases == 0) begin
      $display("no cases were read from the case file");
      load_errs++;
    end
    cycle_limit = 16 + n_cases * (max_hold + 4) + 50;

    repeat (16) @(negedge clk);
    rst_n = 1'b1;

    for (int i = 0; i < n_cases; i++) begin
      run_case(i);
    end
    @(negedge clk);
    drive_idle();

    $display("cases %0d, errors: rdata %0d, busy %0d, irq %0d, epc %0d, load %0d",
             n_cases, rdata_errs, busy_errs, irq_errs, epc_errs, load_errs);
    if (rdata_errs + busy_errs + irq_errs + epc_errs + load_errs == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: source/csr_file_top.sv
// machine-mode CSR file top level, access unit, trap registers and counters
`default_nettype none

module csr_file_top
  import csr_pkg::*;
  import perf_pkg::*;
#(
  parameter int unsigned COUNTER_W = 32
) (
  input  logic         clk,
  input  logic         rst_n,
  input  logic [3:0]   core_id_i,
  input  logic [5:0]   cluster_id_i,
  input  logic [23:0]  boot_addr_i,
  input  csr_req_t     csr_req_i,
  input  trap_ctrl_t   trap_i,
  input  pc_set_t      pcs_i,
  input  perf_events_t events_i,
  output csr_data_t    csr_rdata_o,
  output logic         csr_busy_o,
  output logic         irq_enable_o,
  output csr_data_t    epc_o
);

  // access unit to register modules
  csr_data_t wdata_mod;
  logic      csr_we;
  // register modules to access unit
  csr_data_t mach_rdata;
  csr_data_t perf_rdata;
  logic      perf_hit;
  // sampler and bank loop
  perf_vec_t inc_q;
  perf_vec_t pcer;
  logic      pcmr_enable;

  //////////////////////////////
  // register access
  //////////////////////////////
  csr_access_unit u_access (
    .csr_req_i    (csr_req_i),
    .mach_rdata_i (mach_rdata),
    .perf_rdata_i (perf_rdata),
    .perf_hit_i   (perf_hit),
    .csr_rdata_o  (csr_rdata_o),
    .wdata_mod_o  (wdata_mod),
    .csr_we_o     (csr_we)
  );

  machine_trap_regs u_mach (
    .clk          (clk),
    .rst_n        (rst_n),
    .addr_i       (csr_req_i.addr),
    .wdata_mod_i  (wdata_mod),
    .csr_we_i     (csr_we),
    .trap_i       (trap_i),
    .pcs_i        (pcs_i),
    .core_id_i    (core_id_i),
    .cluster_id_i (cluster_id_i),
    .boot_addr_i  (boot_addr_i),
    .mach_rdata_o (mach_rdata),
    .csr_busy_o   (csr_busy_o),
    .irq_enable_o (irq_enable_o),
    .epc_o        (epc_o)
  );

  //////////////////////////////
  // performance counters
  //////////////////////////////
  perf_event_sampler u_sampler (
    .clk           (clk),
    .rst_n         (rst_n),
    .events_i      (events_i),
    .pcer_i        (pcer),
    .pcmr_enable_i (pcmr_enable),
    .inc_q_o       (inc_q)
  );

  perf_counter_bank #(
    .COUNTER_W (COUNTER_W)
  ) u_counters (
    .clk           (clk),
    .rst_n         (rst_n),
    .access_i      (csr_req_i.access),
    .addr_i        (csr_req_i.addr),
    .wdata_mod_i   (wdata_mod),
    .csr_we_i      (csr_we),
    .inc_q_i       (inc_q),
    .pcer_o        (pcer),
    .pcmr_enable_o (pcmr_enable),
    .perf_rdata_o  (perf_rdata),
    .perf_hit_o    (perf_hit)
  );

endmodule

`default_nettype wire

// File: source/perf_counter_bank.sv
// performance counters, event enable and mode registers with decode and read data
`default_nettype none

module perf_counter_bank
  import csr_pkg::*;
  import perf_pkg::*;
#(
  parameter int unsigned COUNTER_W = 32
) (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      access_i,
  input  csr_addr_t addr_i,
  input  csr_data_t wdata_mod_i,
  input  logic      csr_we_i,
  input  perf_vec_t inc_q_i,
  output perf_vec_t pcer_o,
  output logic      pcmr_enable_o,
  output csr_data_t perf_rdata_o,
  output logic      perf_hit_o
);

  logic [N_PERF_EVENTS-1:0][COUNTER_W-1:0] cnt_q, cnt_d;
  perf_vec_t   pcer_q, pcer_d;
  logic [1:0]  pcmr_q, pcmr_d;
  csr_addr_t   cnt_off;
  logic [3:0]  cnt_idx;
  logic        is_cnt;
  logic        is_all;
  logic        is_pcer;
  logic        is_pcmr;
  perf_vec_t   cnt_wsel;

  //////////////////////////////
  // address decode
  //////////////////////////////
  // below-base addresses wrap high and miss
  assign cnt_off = addr_i - PERF_CNT_BASE;
  assign cnt_idx = cnt_off[3:0];
  assign is_cnt  = access_i & (cnt_off < csr_addr_t'(N_PERF_EVENTS));
  assign is_all  = access_i & (addr_i == PERF_CNT_ALL);
  assign is_pcer = access_i & (addr_i == PERF_PCER);
  assign is_pcmr = access_i & (addr_i == PERF_PCMR);

  assign perf_hit_o = is_cnt | is_all | is_pcer | is_pcmr;

  // zero extended with the all-counters address reading zero
  always_comb begin
    perf_rdata_o = '0;
    if (is_cnt) begin
      perf_rdata_o = csr_data_t'(cnt_q[cnt_idx]);
    end else if (is_pcer) begin
      perf_rdata_o = csr_data_t'(pcer_q);
    end else if (is_pcmr) begin
      perf_rdata_o = csr_data_t'(pcmr_q);
    end
  end

  //////////////////////////////
  // counter update
  //////////////////////////////
  always_comb begin
    for (int i = 0; i < N_PERF_EVENTS; i++) begin
      cnt_wsel[i] = csr_we_i & (is_all | (is_cnt & (cnt_idx == 4'(i))));
      cnt_d[i]    = cnt_q[i];
      // at max hold when saturating and wrap otherwise
      if (inc_q_i[i] && ((cnt_q[i] != '1) || !pcmr_q[PCMR_SATURATE_BIT])) begin
        cnt_d[i] = cnt_q[i] + 1'b1;
      end
      // register write wins over increment
      if (cnt_wsel[i]) begin
        cnt_d[i] = wdata_mod_i[COUNTER_W-1:0];
      end
    end
  end

  // enable and mode writes
  always_comb begin
    pcer_d = pcer_q;
    pcmr_d = pcmr_q;
    if (csr_we_i && is_pcer) begin
      pcer_d = wdata_mod_i[N_PERF_EVENTS-1:0];
    end
    if (csr_we_i && is_pcmr) begin
      pcmr_d = wdata_mod_i[1:0];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q  <= '0;
      pcer_q <= '0;
      // enabled and saturating out of reset
      pcmr_q <= 2'b11;
    end else begin
      cnt_q  <= cnt_d;
      pcer_q <= pcer_d;
      pcmr_q <= pcmr_d;
    end
  end

  assign pcer_o        = pcer_q;
  assign pcmr_enable_o = pcmr_q[PCMR_ENABLE_BIT];

endmodule

`default_nettype wire

// File: source/perf_event_sampler.sv
// performance event derivation, enable gating and increment register
`default_nettype none

module perf_event_sampler
  import perf_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  perf_events_t events_i,
  input  perf_vec_t    pcer_i,
  input  logic         pcmr_enable_i,
  output perf_vec_t    inc_q_o
);

  logic      id_valid_q;
  logic      instr;
  perf_vec_t ev;
  perf_vec_t inc_d;

  // retired instruction in id
  assign instr = events_i.id_valid & events_i.is_decoding;

  //////////////////////////////
  // event vector
  //////////////////////////////
  always_comb begin
    ev[EV_CYCLE]        = 1'b1;
    ev[EV_INSTR]        = instr;
    // hazards and control flow use last cycle's id_valid
    ev[EV_LD_STALL]     = events_i.ld_stall & id_valid_q;
    ev[EV_JR_STALL]     = events_i.jr_stall & id_valid_q;
    // fetch wait not caused by a redirect
    ev[EV_IMISS]        = events_i.imiss & ~events_i.pc_set;
    ev[EV_LOAD]         = events_i.mem_load;
    ev[EV_STORE]        = events_i.mem_store;
    ev[EV_JUMP]         = events_i.jump & id_valid_q;
    ev[EV_BRANCH]       = events_i.branch & id_valid_q;
    ev[EV_BRANCH_TAKEN] = events_i.branch & events_i.branch_taken & id_valid_q;
    ev[EV_COMPRESSED]   = instr & events_i.is_compressed;
    ev[EV_CSR_STALL]    = events_i.csr_stall & id_valid_q;
  end

  // per-counter enable and global enable
  assign inc_d = ev & pcer_i & {N_PERF_EVENTS{pcmr_enable_i}};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_valid_q <= 1'b0;
      inc_q_o    <= '0;
    end else begin
      id_valid_q <= events_i.id_valid;
      inc_q_o    <= inc_d;
    end
  end

endmodule

`default_nettype wire

// File: source/machine_trap_regs.sv
// machine status, epc and cause registers, trap entry, mret and machine read mux
`default_nettype none

module machine_trap_regs
  import csr_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  csr_addr_t  addr_i,
  input  csr_data_t  wdata_mod_i,
  input  logic       csr_we_i,
  input  trap_ctrl_t trap_i,
  input  pc_set_t    pcs_i,
  input  logic [3:0] core_id_i,
  input  logic [5:0] cluster_id_i,
  input  logic [23:0] boot_addr_i,
  output csr_data_t  mach_rdata_o,
  output logic       csr_busy_o,
  output logic       irq_enable_o,
  output csr_data_t  epc_o
);

  mstatus_t   mstatus_q, mstatus_d;
  csr_data_t  mepc_q, mepc_d;
  exc_cause_t mcause_q, mcause_d;
  csr_data_t  exception_pc;
  csr_data_t  hart_id;

  // cluster id above core id with bit 4 spare
  assign hart_id = {21'b0, cluster_id_i, 1'b0, core_id_i};

  //////////////////////////////
  // read mux
  //////////////////////////////
  always_comb begin
    mach_rdata_o = '0;
    case (addr_i)
      CSR_MSTATUS: begin
        mach_rdata_o[MSTATUS_MIE_BIT]  = mstatus_q.mie;
        mach_rdata_o[MSTATUS_MPIE_BIT] = mstatus_q.mpie;
        // mpp fixed at machine mode
        mach_rdata_o[MSTATUS_MPP_LSB +: 2] = 2'b11;
      end
      // trap vector follows boot address
      CSR_MTVEC:   mach_rdata_o = {boot_addr_i, 8'h00};
      CSR_MEPC:    mach_rdata_o = mepc_q;
      // interrupt flag at bit 31 and code at the bottom
      CSR_MCAUSE:  mach_rdata_o = {mcause_q[5], 26'b0, mcause_q[4:0]};
      CSR_MHARTID: mach_rdata_o = hart_id;
      CSR_UHARTID: mach_rdata_o = hart_id;
      // id registers not allocated
      CSR_MISA, CSR_MVENDORID, CSR_MARCHID, CSR_MIMPID: mach_rdata_o = '0;
      default:     mach_rdata_o = '0;
    endcase
  end

  // epc or tvec change needs a pipeline flush
  assign csr_busy_o = csr_we_i & ((addr_i == CSR_MEPC) | (addr_i == CSR_MTVEC));

  //////////////////////////////
  // exception pc select
  //////////////////////////////
  always_comb begin
    exception_pc = pcs_i.pc_id;
    if (trap_i.data_load_event) begin
      // load fault reported from ex
      exception_pc = pcs_i.pc_ex;
    end else if (trap_i.save_if) begin
      exception_pc = pcs_i.pc_if;
    end else if (trap_i.save_id) begin
      exception_pc = pcs_i.pc_id;
    end else if (trap_i.save_taken_branch) begin
      exception_pc = pcs_i.branch_target;
    end
  end

  //////////////////////////////
  // next state
  //////////////////////////////
  always_comb begin
    mstatus_d = mstatus_q;
    mepc_d    = mepc_q;
    mcause_d  = mcause_q;

    // register writes with mtvec read only
    if (csr_we_i) begin
      case (addr_i)
        CSR_MSTATUS: begin
          mstatus_d.mie  = wdata_mod_i[MSTATUS_MIE_BIT];
          mstatus_d.mpie = wdata_mod_i[MSTATUS_MPIE_BIT];
        end
        CSR_MEPC:   mepc_d = wdata_mod_i;
        // same layout as the read view
        CSR_MCAUSE: mcause_d = {wdata_mod_i[31], wdata_mod_i[4:0]};
        default: ;
      endcase
    end

    // trap strobes override a write
    if (trap_i.save_cause) begin
      mstatus_d.mpie = mstatus_q.mie;
      mstatus_d.mie  = 1'b0;
      mepc_d         = exception_pc;
      mcause_d       = trap_i.cause;
    end else if (trap_i.restore_mret) begin
      mstatus_d.mie  = mstatus_q.mpie;
      mstatus_d.mpie = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mstatus_q <= '0;
      mepc_q    <= '0;
      mcause_q  <= '0;
    end else begin
      mstatus_q <= mstatus_d;
      mepc_q    <= mepc_d;
      mcause_q  <= mcause_d;
    end
  end

  // direct outputs
  assign irq_enable_o = mstatus_q.mie;
  assign epc_o        = mepc_q;

endmodule

`default_nettype wire

// File: source/csr_access_unit.sv
// read data select, read-modify-write data and write enable for CSR access
`default_nettype none

module csr_access_unit
  import csr_pkg::*;
(
  input  csr_req_t  csr_req_i,
  input  csr_data_t mach_rdata_i,
  input  csr_data_t perf_rdata_i,
  input  logic      perf_hit_i,
  output csr_data_t csr_rdata_o,
  output csr_data_t wdata_mod_o,
  output logic      csr_we_o
);

  // counter bank wins when it claims the address
  assign csr_rdata_o = perf_hit_i ? perf_rdata_i : mach_rdata_i;

  // any real operation writes
  assign csr_we_o = (csr_req_i.op != CSR_OP_NONE);

  //////////////////////////////
  // read-modify-write
  //////////////////////////////
  always_comb begin
    wdata_mod_o = csr_req_i.wdata;
    unique case (csr_req_i.op)
      CSR_OP_WRITE: wdata_mod_o = csr_req_i.wdata;
      // set bits of old value
      CSR_OP_SET:   wdata_mod_o = csr_req_i.wdata | csr_rdata_o;
      // keep old bits where wdata is zero
      CSR_OP_CLEAR: wdata_mod_o = ~csr_req_i.wdata & csr_rdata_o;
      // no write so the value is unused
      default:      wdata_mod_o = csr_req_i.wdata;
    endcase
  end

endmodule

`default_nettype wire

// File: source/perf_pkg.sv
// performance event indices, event inputs and counter bank address map
`default_nettype none

package perf_pkg;

  localparam int unsigned N_PERF_EVENTS = 12;

  // dense counter index per event
  localparam int unsigned EV_CYCLE        = 0;
  localparam int unsigned EV_INSTR        = 1;
  localparam int unsigned EV_LD_STALL     = 2;
  localparam int unsigned EV_JR_STALL     = 3;
  localparam int unsigned EV_IMISS        = 4;
  localparam int unsigned EV_LOAD         = 5;
  localparam int unsigned EV_STORE        = 6;
  localparam int unsigned EV_JUMP         = 7;
  localparam int unsigned EV_BRANCH       = 8;
  localparam int unsigned EV_BRANCH_TAKEN = 9;
  localparam int unsigned EV_COMPRESSED   = 10;
  localparam int unsigned EV_CSR_STALL    = 11;

  // raw per-cycle core status
  typedef struct packed {
    logic id_valid;
    logic is_decoding;
    logic is_compressed;
    logic imiss;
    logic pc_set;
    logic jump;
    logic branch;
    logic branch_taken;
    logic ld_stall;
    logic jr_stall;
    logic csr_stall;
    logic mem_load;
    logic mem_store;
  } perf_events_t;

  typedef logic [N_PERF_EVENTS-1:0] perf_vec_t;

  //////////////////////////////
  // counter bank address map
  //////////////////////////////
  // counter i sits at base + i
  localparam logic [11:0] PERF_CNT_BASE = 12'h780;
  localparam logic [11:0] PERF_CNT_ALL  = 12'h79F;
  localparam logic [11:0] PERF_PCER     = 12'h7A0;
  localparam logic [11:0] PERF_PCMR     = 12'h7A1;

  // mode register bits
  localparam int unsigned PCMR_ENABLE_BIT   = 0;
  localparam int unsigned PCMR_SATURATE_BIT = 1;

endpackage

`default_nettype wire

// File: source/csr_pkg.sv
// CSR address map, register operations, status, request and trap types
`default_nettype none

package csr_pkg;

  // basic words
  typedef logic [11:0] csr_addr_t;
  typedef logic [31:0] csr_data_t;

  // register operations
  typedef enum logic [1:0] {
    CSR_OP_NONE  = 2'b00,
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_e;

  //////////////////////////////
  // machine address map
  //////////////////////////////
  localparam csr_addr_t CSR_MSTATUS   = 12'h300;
  localparam csr_addr_t CSR_MISA      = 12'h301;
  localparam csr_addr_t CSR_MTVEC     = 12'h305;
  localparam csr_addr_t CSR_MEPC      = 12'h341;
  localparam csr_addr_t CSR_MCAUSE    = 12'h342;
  localparam csr_addr_t CSR_MVENDORID = 12'hF11;
  localparam csr_addr_t CSR_MARCHID   = 12'hF12;
  localparam csr_addr_t CSR_MIMPID    = 12'hF13;
  localparam csr_addr_t CSR_MHARTID   = 12'hF14;
  // non-standard copy of mhartid
  localparam csr_addr_t CSR_UHARTID   = 12'h014;

  // mstatus bit positions
  localparam int unsigned MSTATUS_MIE_BIT  = 3;
  localparam int unsigned MSTATUS_MPIE_BIT = 7;
  localparam int unsigned MSTATUS_MPP_LSB  = 11;

  // implemented status bits only
  typedef struct packed {
    logic mie;
    logic mpie;
  } mstatus_t;

  // register access request from the core
  typedef struct packed {
    logic      access;
    csr_addr_t addr;
    csr_data_t wdata;
    csr_op_e   op;
  } csr_req_t;

  // top bit marks an interrupt
  typedef logic [5:0] exc_cause_t;

  // mutually exclusive trap strobes
  typedef struct packed {
    logic       save_cause;
    exc_cause_t cause;
    logic       save_if;
    logic       save_id;
    logic       save_taken_branch;
    logic       data_load_event;
    logic       restore_mret;
  } trap_ctrl_t;

  // candidate exception pcs
  typedef struct packed {
    csr_data_t pc_if;
    csr_data_t pc_id;
    csr_data_t pc_ex;
    csr_data_t branch_target;
  } pc_set_t;

endpackage

`default_nettype wire
